/* verification/fb_patterns.txt */
# Command line: test name, F for fill or S for square
# Read line: test name, R, hex address, hex expected word
pon_border_0 R 0000 FFFF
pon_border_7 R 0007 FFFF
pon_border_40 R 0028 FFFF
pon_border_47 R 002f FFFF
pon_left_8 R 0008 FFFF
pon_odd_9 R 0009 F00F
pon_even_10 R 000a F000
pon_odd_19 R 0013 F00F
sq_cmd S
sq_p0_18 R 0012 F01F
sq_p0_21 R 0015 F01F
sq_p0_26 R 001a F01F
sq_p0_29 R 001d F01F
sq_p1_66 R 0042 F01F
sq_p1_77 R 004d F01F
sq_out_odd_25 R 0019 F00F
sq_out_even_22 R 0016 F000
fill_cmd F
fill_odd_19 R 0013 F02F
fill_even_18 R 0012 F000
fill_border_15 R 000f FFFF
fill_p1_69 R 0045 F01F
fill_p1_74 R 004a F01F
sq2_cmd S
sq2_p1_67 R 0043 F03F
sq2_out_odd_9 R 0009 F02F

/* list.f */
src/fb_pkg.sv
src/test_pattern.sv
src/vram_arbiter.sv
src/vram.sv
src/fb_test_top.sv
verification/fb_checker.sv
verification/tb_fb_test.sv

/* Makefile */
# Verilator build and run of the framebuffer bring-up testbench

run: obj_dir/Vtb_fb_test
	./obj_dir/Vtb_fb_test > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi

obj_dir/Vtb_fb_test: list.f $(wildcard src/*.sv verification/*.sv)
	verilator --binary --assert -Wno-fatal --top-module tb_fb_test -f list.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* verification/tb_fb_test.sv */
/*
 * Framebuffer bring-up testbench: clock, reset, pattern-file commands
 * and host reads, random reads checked against a shadow image
 */

`timescale 1ns/1ps

module tb_fb_test;

    localparam int NAME_W     = 8 * 24;
    localparam int TIMEOUT    = 2000;
    localparam int FB_W       = 8;
    localparam int FB_H       = 6;
    localparam int SQ_W       = 4;
    localparam int SQ_H       = 2;
    localparam int PAGE       = FB_W * FB_H;
    localparam int RAND_READS = 4;

    logic              clk;
    logic              reset_i;
    logic              fill_i;
    logic              fill_square_i;
    logic              rd_req_i;
    logic [15:0]       rd_addr_i;
    logic              rd_ack_o;
    logic [15:0]       rd_data_o;
    logic              busy_o;

    logic              check_en;
    logic              fault;
    logic              report;
    logic [NAME_W-1:0] exp_name;
    logic [15:0]       exp_value;
    int                pass_cnt;
    int                fail_cnt;

    logic [15:0]       shadow [2*PAGE];    // Expected memory contents
    logic              known [2*PAGE];     // Word has been written
    logic [11:0]       bg;
    integer            seed;
    logic              aborted;

    fb_test_top u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .fill_i        (fill_i),
        .fill_square_i (fill_square_i),
        .rd_req_i      (rd_req_i),
        .rd_addr_i     (rd_addr_i),
        .rd_ack_o      (rd_ack_o),
        .rd_data_o     (rd_data_o),
        .busy_o        (busy_o)
    );

    fb_checker #(
        .NAME_W (NAME_W)
    ) u_check (
        .clk        (clk),
        .reset_i    (reset_i),
        .busy_i     (busy_o),
        .rd_ack_i   (rd_ack_o),
        .rd_data_i  (rd_data_o),
        .check_en_i (check_en),
        .name_i     (exp_name),
        .expected_i (exp_value),
        .fault_i    (fault),
        .report_i   (report),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ------------------------------------------------------------------------
    // Shadow image, built from the image rules
    // ------------------------------------------------------------------------
    task automatic shadow_fill();
        int a;
        int line;
        int col;
        for (a = 0; a < PAGE; a++) begin
            line = a / FB_W;
            col  = a % FB_W;
            if (line == 0 || line == FB_H - 1 || col == 0 || col == FB_W - 1) begin
                shadow[a] = 16'hFFFF;
            end else if (a % 2 == 1) begin
                shadow[a] = {4'hF, bg};
            end else begin
                shadow[a] = 16'hF000;
            end
            known[a] = 1'b1;
        end
    endtask

    task automatic shadow_square();
        int line;
        int col;
        int off;
        for (line = 0; line < SQ_H; line++) begin
            for (col = 0; col < SQ_W; col++) begin
                off = ((FB_H - SQ_H) / 2 + line) * FB_W + (FB_W - SQ_W) / 2 + col;
                shadow[off]        = {4'hF, bg};
                shadow[off + PAGE] = {4'hF, bg};   // Same offset in page 1
                known[off + PAGE]  = 1'b1;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------------
    task automatic stall(input string what);
        $display("Timeout after %0d cycles: %0s", TIMEOUT, what);
        aborted = 1'b1;
        fault <= 1'b1;
        @(posedge clk);
        fault <= 1'b0;
    endtask

    task automatic wait_ack_level(input logic level);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (rd_ack_o !== level && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rd_ack_o !== level) begin
            if (level) stall("host read ack never rose after the request");
            else       stall("host read ack never fell after the request dropped");
        end
    endtask

    task automatic wait_busy_low(input logic [NAME_W-1:0] name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (busy_o !== 1'b0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (busy_o !== 1'b0) begin
            stall($sformatf("busy_o stayed high, %0s never finished", name));
        end
    endtask

    task automatic host_read(input logic [NAME_W-1:0] name, input logic [15:0] addr,
                             input logic check, input logic [15:0] expected);
        if (!aborted) begin
            rd_addr_i <= addr;
            rd_req_i  <= 1'b1;
            check_en  <= check;
            exp_name  <= name;
            exp_value <= expected;
            wait_ack_level(1'b1);
            rd_req_i  <= 1'b0;
            if (!aborted) wait_ack_level(1'b0);
            check_en  <= 1'b0;
        end
    endtask

    // Command with an ignored second pulse and host reads racing the generator
    task automatic run_command(input logic [NAME_W-1:0] name, input logic [7:0] op);
        logic [15:0]       probes [$];
        logic [15:0]       a;
        logic [NAME_W-1:0] rname;
        int                i;
        if (!aborted) begin
            if (op == "F") fill_i <= 1'b1;
            else           fill_square_i <= 1'b1;
            @(posedge clk);
            fill_i        <= 1'b0;
            fill_square_i <= 1'b0;
            bg = bg + 12'h010;
            if (op == "F") shadow_fill();
            else           shadow_square();
            @(posedge clk);
            if (op == "F") fill_square_i <= 1'b1;   // Busy, must be dropped
            else           fill_i <= 1'b1;
            @(posedge clk);
            fill_i        <= 1'b0;
            fill_square_i <= 1'b0;
            for (i = 0; i < RAND_READS; i++) begin
                a = 16'($unsigned($random(seed)) % (2 * PAGE));
                if (!known[a]) a = a % PAGE;
                probes.push_back(a);
                host_read(name, a, 1'b0, 16'h0000);
            end
            wait_busy_low(name);
            for (i = 0; i < probes.size(); i++) begin
                $sformat(rname, "%0s_rand%0d", name, i);
                host_read(rname, probes[i], 1'b1, shadow[probes[i]]);
            end
        end
    endtask

    task automatic run_patterns();
        int                fd;
        int                n;
        int                r;
        logic              done;
        logic [NAME_W-1:0] name;
        logic [7:0]        op;
        logic [15:0]       addr;
        logic [15:0]       value;
        logic [8*128-1:0]  skip;
        fd = $fopen("verification/fb_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verification/fb_patterns.txt");
            aborted = 1'b1;
        end else begin
            done = 1'b0;
            while (!done && !aborted) begin
                n = $fscanf(fd, "%s", name);
                if (n != 1) begin
                    done = 1'b1;
                end else if (name == NAME_W'("#")) begin
                    r = $fgets(skip, fd);          // Column description line
                end else begin
                    n = $fscanf(fd, "%s", op);
                    if (op == "R") begin
                        n = $fscanf(fd, "%h %h", addr, value);
                        host_read(name, addr, 1'b1, value);
                    end else begin
                        run_command(name, op);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int k;
        reset_i       = 1'b1;
        fill_i        = 1'b0;
        fill_square_i = 1'b0;
        rd_req_i      = 1'b0;
        rd_addr_i     = 16'h0000;
        check_en      = 1'b0;
        fault         = 1'b0;
        report        = 1'b0;
        exp_name      = '0;
        exp_value     = 16'h0000;
        aborted       = 1'b0;
        seed          = 32'hcff;
        bg            = 12'h00F;
        for (k = 0; k < 2 * PAGE; k++) known[k] = 1'b0;
        shadow_fill();                             // Power-on image
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        wait_busy_low(NAME_W'("power-on fill"));
        run_patterns();
        report <= 1'b1;
        repeat (2) @(posedge clk);
        if (aborted || fail_cnt != 0 || pass_cnt == 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

/* verification/fb_checker.sv */
/*
 * Read-back checker: busy after reset, host read data against the
 * expected word of each test, pass and fail counts
 */

`timescale 1ns/1ps

module fb_checker #(
    parameter int NAME_W = 8 * 24
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              busy_i,
    input  logic              rd_ack_i,
    input  logic [15:0]       rd_data_i,
    input  logic              check_en_i,
    input  logic [NAME_W-1:0] name_i,
    input  logic [15:0]       expected_i,
    input  logic              fault_i,
    input  logic              report_i,
    output int                pass_cnt_o,
    output int                fail_cnt_o
);

    int   pass_cnt = 0;
    int   fail_cnt = 0;
    logic ack_q    = 1'b0;
    logic reset_q  = 1'b0;
    logic reported = 1'b0;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    // ------------------------------------------------------------------------
    // Compare on each rising read ack
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        reset_q <= reset_i;
        ack_q   <= rd_ack_i;

        if (reset_q && !reset_i) begin             // Fill must start at once
            if (busy_i === 1'b1) begin
                $display("PASS busy_after_reset");
                pass_cnt++;
            end else begin
                $display("FAIL busy_after_reset: busy_o was low, no power-on fill");
                fail_cnt++;
            end
        end

        if (rd_ack_i === 1'b1 && !ack_q && check_en_i) begin
            if (rd_data_i === expected_i) begin
                $display("PASS %0s read %h", name_i, rd_data_i);
                pass_cnt++;
            end else begin
                $display("MISMATCH %0s expected %h actual %h", name_i, expected_i, rd_data_i);
                fail_cnt++;
            end
        end

        if (fault_i) fail_cnt++;                   // Stalled handshake

        if (report_i && !reported) begin
            reported <= 1'b1;
            $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        end
    end

endmodule

/* src/fb_test_top.sv */
/*
 * Framebuffer bring-up top: pattern generator, arbiter and memory
 */

`timescale 1ns/1ps

module fb_test_top #(
    parameter int FB_WIDTH      = 8,
    parameter int FB_HEIGHT     = 6,
    parameter int SQUARE_WIDTH  = 4,
    parameter int SQUARE_HEIGHT = 2
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      fill_i,
    input  logic                      fill_square_i,
    input  logic                      rd_req_i,
    input  logic [fb_pkg::ADDR_W-1:0] rd_addr_i,
    output logic                      rd_ack_o,
    output logic [15:0]               rd_data_o,
    output logic                      busy_o
);

    // Generator side
    logic                      gen_sel;
    logic                      gen_wr;
    logic [fb_pkg::ADDR_W-1:0] gen_addr;
    fb_pkg::pixel_t            gen_data;
    logic                      gen_ack;

    // Memory side
    logic                      mem_sel;
    logic                      mem_wr;
    logic [fb_pkg::ADDR_W-1:0] mem_addr;
    logic [15:0]               mem_wdata;
    logic                      mem_ack;
    logic [15:0]               mem_rdata;

    test_pattern #(
        .FB_WIDTH      (FB_WIDTH),
        .FB_HEIGHT     (FB_HEIGHT),
        .SQUARE_WIDTH  (SQUARE_WIDTH),
        .SQUARE_HEIGHT (SQUARE_HEIGHT)
    ) u_gen (
        .clk             (clk),
        .reset_i         (reset_i),
        .fill_i          (fill_i),
        .fill_square_i   (fill_square_i),
        .vram_ack_i      (gen_ack),
        .vram_sel_o      (gen_sel),
        .vram_wr_o       (gen_wr),
        .vram_addr_o     (gen_addr),
        .vram_data_out_o (gen_data),
        .busy_o          (busy_o)
    );

    vram_arbiter u_arb (
        .clk         (clk),
        .reset_i     (reset_i),
        .gen_sel_i   (gen_sel),
        .gen_wr_i    (gen_wr),
        .gen_addr_i  (gen_addr),
        .gen_data_i  (gen_data.raw),
        .rd_req_i    (rd_req_i),
        .rd_addr_i   (rd_addr_i),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata),
        .gen_ack_o   (gen_ack),
        .rd_ack_o    (rd_ack_o),
        .rd_data_o   (rd_data_o),
        .mem_sel_o   (mem_sel),
        .mem_wr_o    (mem_wr),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata)
    );

    vram #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .sel_i   (mem_sel),
        .wr_i    (mem_wr),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .ack_o   (mem_ack),
        .rdata_o (mem_rdata)
    );

endmodule

/* src/vram.sv */
/*
 * Two-page video memory of ARGB4444 words with a registered
 * four-phase select/ack response
 */

`timescale 1ns/1ps

module vram #(
    parameter int FB_WIDTH  = 8,
    parameter int FB_HEIGHT = 6
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      sel_i,
    input  logic                      wr_i,
    input  logic [fb_pkg::ADDR_W-1:0] addr_i,
    input  logic [15:0]               wdata_i,
    output logic                      ack_o,
    output logic [15:0]               rdata_o
);

    localparam int DEPTH = 2 * FB_WIDTH * FB_HEIGHT;
    localparam int IDX_W = $clog2(DEPTH);

    logic [15:0]      mem [DEPTH];
    logic             access;
    logic [IDX_W-1:0] idx;

    assign access = sel_i && !ack_o;   // Edge on which ack rises
    assign idx    = addr_i[IDX_W-1:0];

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else if (access) begin
            ack_o <= 1'b1;
        end else if (!sel_i) begin
            ack_o <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (access) begin
            if (wr_i) mem[idx] <= wdata_i;
            else      rdata_o  <= mem[idx];   // Valid with ack
        end
    end

    a_addr_in_range: assert property (@(posedge clk) disable iff (reset_i)
        sel_i |-> addr_i < fb_pkg::ADDR_W'(DEPTH));

endmodule

/* src/vram_arbiter.sv */
/*
 * Video memory arbiter between the host read port and the
 * pattern generator, one four-phase handshake per grant
 */

`timescale 1ns/1ps

module vram_arbiter (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      gen_sel_i,
    input  logic                      gen_wr_i,
    input  logic [fb_pkg::ADDR_W-1:0] gen_addr_i,
    input  logic [15:0]               gen_data_i,
    input  logic                      rd_req_i,
    input  logic [fb_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic                      mem_ack_i,
    input  logic [15:0]               mem_rdata_i,
    output logic                      gen_ack_o,
    output logic                      rd_ack_o,
    output logic [15:0]               rd_data_o,
    output logic                      mem_sel_o,
    output logic                      mem_wr_o,
    output logic [fb_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [15:0]               mem_wdata_o
);

    typedef enum logic [1:0] {OWN_IDLE, OWN_GEN, OWN_HOST} owner_t;

    owner_t owner;
    logic   ack_seen;   // Memory acked the current grant
    logic   release_grant;

    // Grant ends once the memory ack has come and gone
    assign release_grant = (owner != OWN_IDLE) && ack_seen && !mem_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner    <= OWN_IDLE;
            ack_seen <= 1'b0;
        end else if (owner == OWN_IDLE) begin
            if (rd_req_i)       owner <= OWN_HOST;   // Host first
            else if (gen_sel_i) owner <= OWN_GEN;
        end else if (release_grant) begin
            owner    <= OWN_IDLE;
            ack_seen <= 1'b0;
        end else if (mem_ack_i) begin
            ack_seen <= 1'b1;
        end
    end

    assign mem_sel_o   = !release_grant && ((owner == OWN_GEN && gen_sel_i) ||
                                            (owner == OWN_HOST && rd_req_i));
    assign mem_wr_o    = (owner == OWN_GEN) && gen_wr_i;   // Host only reads
    assign mem_addr_o  = (owner == OWN_HOST) ? rd_addr_i : gen_addr_i;
    assign mem_wdata_o = gen_data_i;

    assign gen_ack_o = (owner == OWN_GEN) && mem_ack_i;
    assign rd_ack_o  = (owner == OWN_HOST) && mem_ack_i;
    assign rd_data_o = mem_rdata_i;

    // Grant holds while the memory handshake is open
    a_grant_locked: assert property (@(posedge clk) disable iff (reset_i)
        (mem_sel_o || mem_ack_i) |=> owner == $past(owner));

endmodule

/* src/test_pattern.sv */
/*
 * Test-pattern generator: full-screen border fill of page 0 and a
 * centered background-color rectangle written into both pages
 */

`timescale 1ns/1ps

module test_pattern #(
    parameter int FB_WIDTH      = 8,
    parameter int FB_HEIGHT     = 6,
    parameter int SQUARE_WIDTH  = 4,
    parameter int SQUARE_HEIGHT = 2
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      fill_i,
    input  logic                      fill_square_i,
    input  logic                      vram_ack_i,
    output logic                      vram_sel_o,
    output logic                      vram_wr_o,
    output logic [fb_pkg::ADDR_W-1:0] vram_addr_o,
    output fb_pkg::pixel_t            vram_data_out_o,
    output logic                      busy_o
);

    localparam int AW = fb_pkg::ADDR_W;

    localparam int SQ_COL   = (FB_WIDTH - SQUARE_WIDTH) / 2;
    localparam int SQ_LINE  = (FB_HEIGHT - SQUARE_HEIGHT) / 2;

    localparam logic [AW-1:0] PAGE_SIZE = AW'(FB_WIDTH * FB_HEIGHT);
    localparam logic [AW-1:0] SQ_START  = AW'(FB_WIDTH * SQ_LINE + SQ_COL);
    localparam logic [AW-1:0] LINE_SKIP = AW'(FB_WIDTH - SQUARE_WIDTH + 1);
    localparam logic [AW-1:0] LAST_COL  = AW'(FB_WIDTH - 1);
    localparam logic [AW-1:0] LAST_LINE = AW'(FB_HEIGHT - 1);
    localparam logic [AW-1:0] SQ_LAST_C = AW'(SQUARE_WIDTH - 1);
    localparam logic [AW-1:0] SQ_LAST_L = AW'(SQUARE_HEIGHT - 1);

    typedef enum logic [1:0] {
        ST_ISSUE,   // Present one word to memory
        ST_ACK,     // Hold select until ack
        ST_REL,     // Wait for ack to fall, then step
        ST_HOLD
    } state_t;

    state_t         state;
    logic           square_mode;
    logic           page1;           // Second copy of a square pixel
    logic [AW-1:0]  addr;            // Offset within page 0
    logic [AW-1:0]  line_cnt;
    logic [AW-1:0]  col_cnt;
    logic [11:0]    bg_color;
    logic           on_border;
    logic           last_pixel;
    fb_pkg::pixel_t pix;

    assign busy_o = (state != ST_HOLD);

    assign on_border = (line_cnt == '0) || (line_cnt == LAST_LINE) ||
                       (col_cnt == '0) || (col_cnt == LAST_COL);

    assign last_pixel = square_mode ? (col_cnt == SQ_LAST_C && line_cnt == SQ_LAST_L)
                                    : (col_cnt == LAST_COL && line_cnt == LAST_LINE);

    always_comb begin
        if (!square_mode && on_border) begin
            pix = fb_pkg::BORDER_COLOR;
        end else begin
            pix.argb.a = 4'hF;
            {pix.argb.r, pix.argb.g, pix.argb.b} = (square_mode || addr[0]) ? bg_color
                                                                           : 12'h000;
        end
    end

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= ST_ISSUE;   // Power-on fill of page 0
            square_mode <= 1'b0;
            page1       <= 1'b0;
            addr        <= '0;
            line_cnt    <= '0;
            col_cnt     <= '0;
            bg_color    <= fb_pkg::BG_RESET;
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
        end else begin
            case (state)
                ST_ISSUE: begin
                    vram_sel_o <= 1'b1;
                    vram_wr_o  <= 1'b1;
                    state      <= ST_ACK;
                end
                ST_ACK: begin
                    if (vram_ack_i) begin
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        state      <= ST_REL;
                    end
                end
                ST_REL: begin
                    if (!vram_ack_i) begin
                        if (square_mode && !page1) begin
                            page1 <= 1'b1;         // Same offset in page 1
                            state <= ST_ISSUE;
                        end else begin
                            page1 <= 1'b0;
                            if (col_cnt == (square_mode ? SQ_LAST_C : LAST_COL)) begin
                                col_cnt  <= '0;
                                line_cnt <= line_cnt + 1'b1;
                                addr     <= addr + (square_mode ? LINE_SKIP : AW'(1));
                            end else begin
                                col_cnt <= col_cnt + 1'b1;
                                addr    <= addr + 1'b1;
                            end
                            state <= last_pixel ? ST_HOLD : ST_ISSUE;
                        end
                    end
                end
                ST_HOLD: begin
                    if (fill_i || fill_square_i) begin
                        square_mode <= !fill_i;    // Fill wins
                        addr        <= fill_i ? '0 : SQ_START;
                        line_cnt    <= '0;
                        col_cnt     <= '0;
                        bg_color    <= bg_color + fb_pkg::BG_STEP;
                        state       <= ST_ISSUE;
                    end
                end
                default: state <= ST_HOLD;
            endcase
        end
    end

    // Address and word are latched as the select goes up
    always_ff @(posedge clk) begin
        if (state == ST_ISSUE) begin
            vram_addr_o     <= page1 ? addr + PAGE_SIZE : addr;
            vram_data_out_o <= pix;
        end
    end

    // A new select only after the previous ack has dropped
    a_sel_after_ack_low: assert property (@(posedge clk) disable iff (reset_i)
        $rose(vram_sel_o) |-> !vram_ack_i);

endmodule

/* src/fb_pkg.sv */
/*
 * Framebuffer bring-up definitions: ARGB4444 pixel union,
 * color constants and the video memory address width
 */

package fb_pkg;

    localparam int ADDR_W = 16;

    // ------------------------------------------------------------------------
    // Pixel word, seen either as one raw word or as four color nibbles
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [3:0] a;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } argb_t;

    typedef union packed {
        logic [15:0] raw;
        argb_t       argb;
    } pixel_t;

    // ------------------------------------------------------------------------
    // Colors
    // ------------------------------------------------------------------------
    localparam pixel_t      BORDER_COLOR = 16'hFFFF;
    localparam logic [11:0] BG_RESET     = 12'h00F;   // Blue after reset
    localparam logic [11:0] BG_STEP      = 12'h010;   // One green step

endpackage
